//--- hdl/mode_decide_pkg.sv
//--------------------------------------
// Shared sizes, mode encodings and bus structs for a 4x4 luma block
// with two 2x2 chroma blocks; pixels are unsigned 8 bit
//--------------------------------------
package mode_decide_pkg;

    localparam int LUMA_PIX   = 16;
    localparam int CHROMA_PIX = 4;
    localparam int SUB_BLOCKS = 4;
    localparam int SCORE_W    = 20;

    // Mode costs, scaled by lambda
    localparam logic [1:0] COST_DC = 2'd0;
    localparam logic [1:0] COST_V  = 2'd1;
    localparam logic [1:0] COST_H  = 2'd1;
    localparam logic [1:0] COST_TM = 2'd2;

    typedef enum logic [1:0] {
        I16_DC,
        I16_V,
        I16_H,
        I16_TM
    } i16_mode_e;

    typedef enum logic [1:0] {
        I4_DC,
        I4_V,
        I4_H
    } i4_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DECIDE
    } ctrl_state_e;

    //--------------------------------------
    // Buses
    //--------------------------------------
    typedef struct packed {
        logic [LUMA_PIX-1:0][7:0]   y;
        logic [CHROMA_PIX-1:0][7:0] u;
        logic [CHROMA_PIX-1:0][7:0] v;
    } mb_pixels_t;

    typedef struct packed {
        logic [3:0][7:0] top_y;
        logic [3:0][7:0] left_y;
        logic [7:0]      top_left_y;
        logic [1:0][7:0] top_u;
        logic [1:0][7:0] left_u;
        logic [1:0][7:0] top_v;
        logic [1:0][7:0] left_v;
    } mb_edges_t;

    typedef struct packed {
        logic [7:0] lambda_i16;
        logic [7:0] lambda_i4;
        logic [2:0] qshift;
    } quant_cfg_t;

    typedef struct packed {
        logic                          mbtype;
        i16_mode_e                     mode_i16;
        i4_mode_e [SUB_BLOCKS-1:0]     modes_i4;
        logic [LUMA_PIX-1:0]           nz_luma;
        logic [2*CHROMA_PIX-1:0]       nz_chroma;
        logic                          skipped;
    } mb_result_t;

endpackage

//--- hdl/intra16_scorer.sv
//--------------------------------------
// Whole-block luma scorer, one mode per cycle, done 4 cycles after go
// Outputs hold from done until the next go
//--------------------------------------
`timescale 1ns/1ps

module intra16_scorer
    import mode_decide_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                go,
    input  mb_pixels_t          pix,
    input  mb_edges_t           edges,
    input  quant_cfg_t          cfg,
    output logic [SCORE_W-1:0]  score,
    output i16_mode_e           mode,
    output logic [LUMA_PIX-1:0] nz,
    output logic                done
);

    mb_pixels_t          pix_q;
    mb_edges_t           edges_q;
    quant_cfg_t          cfg_q;
    logic                busy;
    i16_mode_e           cur;
    logic [SCORE_W-1:0]  cand_score;
    logic [LUMA_PIX-1:0] cand_nz;

    // Residuals, SAD and nonzero mask of the current mode
    always_comb begin
        logic [10:0]       edge_sum;
        logic [7:0]        dc_pred;
        logic [7:0]        pred;
        logic signed [9:0] tm;
        logic signed [9:0] diff;
        logic [7:0]        mag;
        logic [1:0]        cost;
        logic [SCORE_W-1:0] sad;

        edge_sum = '0;
        for (int k = 0; k < 4; k++) begin
            edge_sum = edge_sum + 11'(edges_q.top_y[k]) + 11'(edges_q.left_y[k]);
        end
        dc_pred = 8'((edge_sum + 11'd4) >> 3);

        sad = '0;
        for (int i = 0; i < LUMA_PIX; i++) begin
            tm = $signed({2'b00, edges_q.left_y[i / 4]})
               + $signed({2'b00, edges_q.top_y[i % 4]})
               - $signed({2'b00, edges_q.top_left_y});
            case (cur)
                I16_V:   pred = edges_q.top_y[i % 4];
                I16_H:   pred = edges_q.left_y[i / 4];
                I16_TM:  pred = (tm < 0) ? 8'd0 : ((tm > 10'sd255) ? 8'd255 : tm[7:0]);
                default: pred = dc_pred;
            endcase
            diff = $signed({2'b00, pix_q.y[i]}) - $signed({2'b00, pred});
            mag = diff[9] ? 8'(-diff) : diff[7:0];
            cand_nz[i] = (mag >> cfg_q.qshift) != 8'd0;
            sad = sad + SCORE_W'(mag);
        end

        case (cur)
            I16_V:   cost = COST_V;
            I16_H:   cost = COST_H;
            I16_TM:  cost = COST_TM;
            default: cost = COST_DC;
        endcase
        cand_score = sad + SCORE_W'(cfg_q.lambda_i16) * SCORE_W'(cost);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cur  <= I16_DC;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                busy <= 1'b1;
                cur  <= I16_DC;
            end else if (busy) begin
                cur <= i16_mode_e'(cur + 2'd1);
                if (cur == I16_TM) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // DC seeds the best so far
    always_ff @(posedge clk) begin
        if (go) begin
            pix_q   <= pix;
            edges_q <= edges;
            cfg_q   <= cfg;
        end
        if (busy && (cur == I16_DC || cand_score < score)) begin
            score <= cand_score;
            mode  <= cur;
            nz    <= cand_nz;
        end
    end

    // Four mode steps, then a single done pulse
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        go |=> !done [*4] ##1 done ##1 !done);

endmodule

//--- hdl/intra4_scorer.sv
//--------------------------------------
// Split luma scorer over four 2x2 sub-blocks, done 12 cycles after go
// Inner neighbours are taken from source pixels, not reconstruction
//--------------------------------------
`timescale 1ns/1ps

module intra4_scorer
    import mode_decide_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      go,
    input  mb_pixels_t                pix,
    input  mb_edges_t                 edges,
    input  quant_cfg_t                cfg,
    output logic [SCORE_W-1:0]        score,
    output i4_mode_e [SUB_BLOCKS-1:0] modes,
    output logic [LUMA_PIX-1:0]       nz,
    output logic                      done
);

    mb_pixels_t         pix_q;
    mb_edges_t          edges_q;
    quant_cfg_t         cfg_q;
    logic               busy;
    logic [3:0]         cnt;
    logic [1:0]         sb;
    i4_mode_e           md;
    logic [SCORE_W-1:0] cand_score;
    logic [3:0]         cand_nz;
    logic [SCORE_W-1:0] best_score;
    i4_mode_e           best_mode;
    logic [3:0]         best_nz;
    logic [SCORE_W-1:0] sel_score;
    i4_mode_e           sel_mode;
    logic [3:0]         sel_nz;

    // Raster index of pixel p inside sub-block b
    function automatic int pix_index(input logic [1:0] b, input int p);
        return (2 * b[1] + p / 2) * 4 + 2 * b[0] + p % 2;
    endfunction

    assign sb = 2'(cnt / 4'd3);
    assign md = i4_mode_e'(2'(cnt % 4'd3));

    always_comb begin
        logic [1:0][7:0]   top;
        logic [1:0][7:0]   left;
        logic [7:0]        dc_pred;
        logic [7:0]        pred;
        logic signed [9:0] diff;
        logic [7:0]        mag;
        logic [1:0]        cost;
        logic [SCORE_W-1:0] sad;

        // Block edge or the pixels just above / left inside the block
        for (int k = 0; k < 2; k++) begin
            top[k]  = sb[1] ? pix_q.y[4 + 2 * sb[0] + k] : edges_q.top_y[2 * sb[0] + k];
            left[k] = sb[0] ? pix_q.y[(2 * sb[1] + k) * 4 + 1]
                            : edges_q.left_y[2 * sb[1] + k];
        end
        dc_pred = 8'((10'(top[0]) + 10'(top[1]) + 10'(left[0]) + 10'(left[1]) + 10'd2) >> 2);

        sad = '0;
        for (int p = 0; p < 4; p++) begin
            case (md)
                I4_V:    pred = top[p % 2];
                I4_H:    pred = left[p / 2];
                default: pred = dc_pred;
            endcase
            diff = $signed({2'b00, pix_q.y[pix_index(sb, p)]}) - $signed({2'b00, pred});
            mag = diff[9] ? 8'(-diff) : diff[7:0];
            cand_nz[p] = (mag >> cfg_q.qshift) != 8'd0;
            sad = sad + SCORE_W'(mag);
        end

        cost = (md == I4_DC) ? COST_DC : ((md == I4_V) ? COST_V : COST_H);
        cand_score = sad + SCORE_W'(cfg_q.lambda_i4) * SCORE_W'(cost);

        // Final pick for the sub-block on its last mode
        if (cand_score < best_score) begin
            sel_score = cand_score;
            sel_mode  = md;
            sel_nz    = cand_nz;
        end else begin
            sel_score = best_score;
            sel_mode  = best_mode;
            sel_nz    = best_nz;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == 4'd11) begin
                    busy <= 1'b0;
                    cnt  <= '0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            pix_q   <= pix;
            edges_q <= edges;
            cfg_q   <= cfg;
            score   <= '0;
        end else if (busy) begin
            if (md == I4_DC || cand_score < best_score) begin
                best_score <= cand_score;
                best_mode  <= md;
                best_nz    <= cand_nz;
            end
            if (md == I4_H) begin
                score     <= score + sel_score;
                modes[sb] <= sel_mode;
                for (int p = 0; p < 4; p++) begin
                    nz[pix_index(sb, p)] <= sel_nz[p];
                end
            end
        end
    end

    // Twelve pairs within range, then a single done pulse
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        go |=> (!done && cnt <= 4'd11) [*12] ##1 done ##1 !done);

endmodule

//--- hdl/chroma_nz.sv
//--------------------------------------
// Chroma DC prediction and nonzero flags, valid 1 cycle after go
//--------------------------------------
`timescale 1ns/1ps

module chroma_nz
    import mode_decide_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    go,
    input  mb_pixels_t              pix,
    input  mb_edges_t               edges,
    input  quant_cfg_t              cfg,
    output logic [2*CHROMA_PIX-1:0] nz
);

    // DC prediction of one 2x2 block and its nonzero flags
    function automatic logic [CHROMA_PIX-1:0] dc_nz(
        input logic [CHROMA_PIX-1:0][7:0] src,
        input logic [1:0][7:0]            top,
        input logic [1:0][7:0]            left,
        input logic [2:0]                 qshift
    );
        logic [7:0]              pred;
        logic signed [9:0]       diff;
        logic [7:0]              mag;
        logic [CHROMA_PIX-1:0]   flags;

        pred = 8'((10'(top[0]) + 10'(top[1]) + 10'(left[0]) + 10'(left[1]) + 10'd2) >> 2);
        for (int i = 0; i < CHROMA_PIX; i++) begin
            diff = $signed({2'b00, src[i]}) - $signed({2'b00, pred});
            mag = diff[9] ? 8'(-diff) : diff[7:0];
            flags[i] = (mag >> qshift) != 8'd0;
        end
        return flags;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nz <= '0;
        end else if (go) begin
            // V in the upper nibble
            nz <= {dc_nz(pix.v, edges.top_v, edges.left_v, cfg.qshift),
                   dc_nz(pix.u, edges.top_u, edges.left_u, cfg.qshift)};
        end
    end

endmodule

//--- hdl/mb_decide_ctrl.sv
//--------------------------------------
// Sequences the scorers and picks the block type; start is dropped
// unless idle, done pulses 14 cycles after an accepted start
//--------------------------------------
`timescale 1ns/1ps

module mb_decide_ctrl
    import mode_decide_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output logic                      go,
    input  logic                      i16_done,
    input  logic                      i4_done,
    input  logic [SCORE_W-1:0]        i16_score,
    input  logic [SCORE_W-1:0]        i4_score,
    input  i16_mode_e                 i16_mode,
    input  i4_mode_e [SUB_BLOCKS-1:0] i4_modes,
    input  logic [LUMA_PIX-1:0]       i16_nz,
    input  logic [LUMA_PIX-1:0]       i4_nz,
    input  logic [2*CHROMA_PIX-1:0]   chroma_nz,
    output mb_result_t                result,
    output logic                      done
);

    ctrl_state_e         state;
    logic                seen_i16;
    logic                seen_i4;
    logic                use_i16;
    logic [LUMA_PIX-1:0] luma_nz;

    assign go = start && (state == ST_IDLE);

    // Whole-block wins ties
    assign use_i16 = (i4_score >= i16_score);
    assign luma_nz = use_i16 ? i16_nz : i4_nz;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            seen_i16 <= 1'b0;
            seen_i4  <= 1'b0;
            result   <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state    <= ST_RUN;
                        seen_i16 <= 1'b0;
                        seen_i4  <= 1'b0;
                    end
                end
                ST_RUN: begin
                    seen_i16 <= seen_i16 | i16_done;
                    seen_i4  <= seen_i4 | i4_done;
                    if ((seen_i16 || i16_done) && (seen_i4 || i4_done)) begin
                        state <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    result.mbtype    <= use_i16;
                    result.mode_i16  <= i16_mode;
                    result.modes_i4  <= i4_modes;
                    result.nz_luma   <= luma_nz;
                    result.nz_chroma <= chroma_nz;
                    result.skipped   <= (luma_nz == '0) && (chroma_nz == '0);
                    done             <= 1'b1;
                    state            <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One done per accepted start, after the full scorer latency
    a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
        go |=> (!done && !go) [*14] ##1 done ##1 !done);

endmodule

//--- hdl/mode_decide_top.sv
//--------------------------------------
// Intra mode decision top; inputs must hold from start until done
//--------------------------------------
`timescale 1ns/1ps

module mode_decide_top
    import mode_decide_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  mb_pixels_t pix,
    input  mb_edges_t  edges,
    input  quant_cfg_t cfg,
    output mb_result_t result,
    output logic       done
);

    logic                      go;
    logic                      i16_done;
    logic                      i4_done;
    logic [SCORE_W-1:0]        i16_score;
    logic [SCORE_W-1:0]        i4_score;
    i16_mode_e                 i16_mode;
    i4_mode_e [SUB_BLOCKS-1:0] i4_modes;
    logic [LUMA_PIX-1:0]       i16_nz;
    logic [LUMA_PIX-1:0]       i4_nz;
    logic [2*CHROMA_PIX-1:0]   c_nz;

    mb_decide_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .go        (go),
        .i16_done  (i16_done),
        .i4_done   (i4_done),
        .i16_score (i16_score),
        .i4_score  (i4_score),
        .i16_mode  (i16_mode),
        .i4_modes  (i4_modes),
        .i16_nz    (i16_nz),
        .i4_nz     (i4_nz),
        .chroma_nz (c_nz),
        .result    (result),
        .done      (done)
    );

    intra16_scorer u_i16 (
        .clk   (clk),
        .rst_n (rst_n),
        .go    (go),
        .pix   (pix),
        .edges (edges),
        .cfg   (cfg),
        .score (i16_score),
        .mode  (i16_mode),
        .nz    (i16_nz),
        .done  (i16_done)
    );

    intra4_scorer u_i4 (
        .clk   (clk),
        .rst_n (rst_n),
        .go    (go),
        .pix   (pix),
        .edges (edges),
        .cfg   (cfg),
        .score (i4_score),
        .modes (i4_modes),
        .nz    (i4_nz),
        .done  (i4_done)
    );

    chroma_nz u_chroma (
        .clk   (clk),
        .rst_n (rst_n),
        .go    (go),
        .pix   (pix),
        .edges (edges),
        .cfg   (cfg),
        .nz    (c_nz)
    );

endmodule

//--- verif/mode_decide_checker.sv
//--------------------------------------
// Compares each result at done with the table entry, or for random
// blocks with a model of the decision rules; samples on falling edges
//--------------------------------------
`timescale 1ns/1ps

module mode_decide_checker
    import mode_decide_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            done,
    input  mb_result_t      result,
    input  mb_pixels_t      pix,
    input  mb_edges_t       edges,
    input  quant_cfg_t      cfg,
    input  mb_result_t      exp_res,
    input  logic            use_model,
    input  logic [8*12-1:0] name,
    output int              n_pass,
    output int              n_fail,
    output int              n_done
);

    function automatic int absdiff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // DC predicted 2x2 chroma block
    function automatic logic [3:0] chroma_flags(
        input logic [3:0][7:0] src,
        input logic [1:0][7:0] top,
        input logic [1:0][7:0] left,
        input int              q
    );
        int         pred;
        logic [3:0] f;

        pred = (int'(top[0]) + int'(top[1]) + int'(left[0]) + int'(left[1]) + 2) >> 2;
        for (int i = 0; i < 4; i++) begin
            f[i] = (absdiff(src[i], pred) >> q) != 0;
        end
        return f;
    endfunction

    function automatic mb_result_t decide_model(
        input mb_pixels_t p,
        input mb_edges_t  e,
        input quant_cfg_t c
    );
        mb_result_t          r;
        int                  dc;
        int                  pred;
        int                  d;
        int                  s;
        int                  best;
        int                  best16;
        int                  sum4;
        int                  row;
        int                  col;
        int                  t[2];
        int                  l[2];
        logic [LUMA_PIX-1:0] m_nz;
        logic [LUMA_PIX-1:0] nz16;
        logic [LUMA_PIX-1:0] nz4;
        logic [3:0]          sub_nz;
        logic [3:0]          best_nz;

        r = '0;
        dc = 4;
        for (int k = 0; k < 4; k++) begin
            dc = dc + e.top_y[k] + e.left_y[k];
        end
        dc = dc >> 3;
        best16 = 0;
        nz16 = '0;
        for (int m = 0; m < 4; m++) begin
            s = c.lambda_i16 * ((m == 0) ? 0 : ((m == 3) ? 2 : 1));
            m_nz = '0;
            for (int i = 0; i < LUMA_PIX; i++) begin
                row = i / 4;
                col = i % 4;
                case (m)
                    0: pred = dc;
                    1: pred = e.top_y[col];
                    2: pred = e.left_y[row];
                    default: begin
                        pred = int'(e.left_y[row]) + int'(e.top_y[col]) - int'(e.top_left_y);
                        pred = (pred < 0) ? 0 : ((pred > 255) ? 255 : pred);
                    end
                endcase
                d = absdiff(p.y[i], pred);
                s = s + d;
                m_nz[i] = (d >> c.qshift) != 0;
            end
            if (m == 0 || s < best16) begin
                best16 = s;
                r.mode_i16 = i16_mode_e'(m);
                nz16 = m_nz;
            end
        end

        // Split coding, neighbours from source pixels inside the block
        sum4 = 0;
        nz4 = '0;
        for (int b = 0; b < SUB_BLOCKS; b++) begin
            row = 2 * (b / 2);
            col = 2 * (b % 2);
            for (int k = 0; k < 2; k++) begin
                t[k] = (row == 0) ? e.top_y[col + k] : p.y[(row - 1) * 4 + col + k];
                l[k] = (col == 0) ? e.left_y[row + k] : p.y[(row + k) * 4 + col - 1];
            end
            dc = (t[0] + t[1] + l[0] + l[1] + 2) >> 2;
            best = 0;
            best_nz = '0;
            for (int m = 0; m < 3; m++) begin
                s = c.lambda_i4 * ((m == 0) ? 0 : 1);
                for (int q = 0; q < 4; q++) begin
                    pred = (m == 0) ? dc : ((m == 1) ? t[q % 2] : l[q / 2]);
                    d = absdiff(p.y[(row + q / 2) * 4 + col + q % 2], pred);
                    s = s + d;
                    sub_nz[q] = (d >> c.qshift) != 0;
                end
                if (m == 0 || s < best) begin
                    best = s;
                    r.modes_i4[b] = i4_mode_e'(m);
                    best_nz = sub_nz;
                end
            end
            sum4 = sum4 + best;
            for (int q = 0; q < 4; q++) begin
                nz4[(row + q / 2) * 4 + col + q % 2] = best_nz[q];
            end
        end

        r.nz_chroma = {chroma_flags(p.v, e.top_v, e.left_v, c.qshift),
                       chroma_flags(p.u, e.top_u, e.left_u, c.qshift)};
        r.mbtype = (sum4 >= best16);
        r.nz_luma = r.mbtype ? nz16 : nz4;
        r.skipped = (r.nz_luma == '0) && (r.nz_chroma == '0);
        return r;
    endfunction

    always @(negedge clk) begin
        mb_result_t expv;
        if (rst_n && done) begin
            expv = use_model ? decide_model(pix, edges, cfg) : exp_res;
            n_done++;
            if (result === expv) begin
                n_pass++;
                $display("[PASS] %s", name);
            end else begin
                n_fail++;
                $display("[FAIL] %s expected %h actual %h", name, expv, result);
            end
        end
    end

endmodule

//--- verif/tb_mode_decide.sv
//--------------------------------------
// Directed table then seeded random blocks, one start per entry;
// inputs hold from start until done
//--------------------------------------
`timescale 1ns/1ps

module tb_mode_decide
    import mode_decide_pkg::*;
();

    localparam int NAME_W     = 8 * 12;
    localparam int N_DIRECTED = 6;
    localparam int N_RANDOM   = 8;
    localparam int LATENCY    = 14;
    localparam int DONE_WAIT  = 40;
    localparam int POKE_AT    = 5;
    localparam int QUIET      = 20;
    localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 16 + 200;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        mb_pixels_t        pix;
        mb_edges_t         edges;
        quant_cfg_t        cfg;
        mb_result_t        exp;
        logic              poke;
    } test_entry_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              start;
    mb_pixels_t        pix;
    mb_edges_t         edges;
    quant_cfg_t        cfg;
    mb_result_t        result;
    logic              done;
    mb_result_t        exp_res;
    logic              use_model;
    logic [NAME_W-1:0] cur_name;
    int                n_pass;
    int                n_fail;
    int                n_done;
    int                n_started = 0;
    int                other_errs = 0;
    int                cycle_cnt = 0;
    test_entry_t       tests[N_DIRECTED];

    always #20 clk = ~clk;

    mode_decide_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .pix    (pix),
        .edges  (edges),
        .cfg    (cfg),
        .result (result),
        .done   (done)
    );

    mode_decide_checker u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .result    (result),
        .pix       (pix),
        .edges     (edges),
        .cfg       (cfg),
        .exp_res   (exp_res),
        .use_model (use_model),
        .name      (cur_name),
        .n_pass    (n_pass),
        .n_fail    (n_fail),
        .n_done    (n_done)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped, no finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic mb_pixels_t flat_pixels(input logic [7:0] lvl);
        mb_pixels_t p;
        for (int i = 0; i < LUMA_PIX; i++) begin
            p.y[i] = lvl;
        end
        for (int i = 0; i < CHROMA_PIX; i++) begin
            p.u[i] = lvl;
            p.v[i] = lvl;
        end
        return p;
    endfunction

    function automatic mb_edges_t flat_edges(input logic [7:0] lvl);
        mb_edges_t e;
        e.top_y      = {4{lvl}};
        e.left_y     = {4{lvl}};
        e.top_left_y = lvl;
        e.top_u      = {2{lvl}};
        e.left_u     = {2{lvl}};
        e.top_v      = {2{lvl}};
        e.left_v     = {2{lvl}};
        return e;
    endfunction

    function automatic quant_cfg_t make_cfg(input int l16, input int l4, input int q);
        quant_cfg_t c;
        c.lambda_i16 = 8'(l16);
        c.lambda_i4  = 8'(l4);
        c.qshift     = 3'(q);
        return c;
    endfunction

    function automatic mb_result_t build_result(
        input logic mbtype, input i16_mode_e m16,
        input i4_mode_e m0, input i4_mode_e m1, input i4_mode_e m2, input i4_mode_e m3,
        input logic [15:0] nzl, input logic [7:0] nzc, input logic skip
    );
        mb_result_t r;
        r.mbtype      = mbtype;
        r.mode_i16    = m16;
        r.modes_i4[0] = m0;
        r.modes_i4[1] = m1;
        r.modes_i4[2] = m2;
        r.modes_i4[3] = m3;
        r.nz_luma     = nzl;
        r.nz_chroma   = nzc;
        r.skipped     = skip;
        return r;
    endfunction

    task automatic add_test(
        input int idx, input logic [NAME_W-1:0] name, input mb_pixels_t p,
        input mb_edges_t e, input quant_cfg_t c, input mb_result_t r, input logic poke
    );
        tests[idx].name  = name;
        tests[idx].pix   = p;
        tests[idx].edges = e;
        tests[idx].cfg   = c;
        tests[idx].exp   = r;
        tests[idx].poke  = poke;
    endtask

    task automatic fill_table();
        mb_pixels_t p;
        mb_edges_t  e;
        mb_result_t r;

        add_test(0, "flat_block", flat_pixels(8'd100), flat_edges(8'd100), make_cfg(10, 10, 0),
                 build_result(1'b1, I16_DC, I4_DC, I4_DC, I4_DC, I4_DC, 16'h0, 8'h00, 1'b1),
                 1'b0);

        // Rows repeat the top edge, left edge unrelated
        e = flat_edges(8'd128);
        e.top_y      = {8'd200, 8'd120, 8'd60, 8'd10};
        e.left_y     = {4{8'd90}};
        e.top_left_y = 8'd50;
        p = flat_pixels(8'd128);
        for (int i = 0; i < LUMA_PIX; i++) begin
            p.y[i] = e.top_y[i % 4];
        end
        add_test(1, "vert_stripes", p, e, make_cfg(4, 4, 0),
                 build_result(1'b1, I16_V, I4_V, I4_V, I4_V, I4_V, 16'h0, 8'h00, 1'b1), 1'b0);

        // Sub-blocks at 20, 80, 140, 200; TM is exact but pays 2 x 200
        e = flat_edges(8'd128);
        e.top_y      = {8'd80, 8'd80, 8'd20, 8'd20};
        e.left_y     = {8'd140, 8'd140, 8'd20, 8'd20};
        e.top_left_y = 8'd20;
        p = flat_pixels(8'd128);
        for (int i = 0; i < LUMA_PIX; i++) begin
            p.y[i] = 8'(20 + 60 * ((i / 8) * 2 + (i % 4) / 2));
        end
        r = build_result(1'b0, I16_TM, I4_DC, I4_V, I4_H, I4_H, 16'hcc00, 8'h00, 1'b0);
        add_test(2, "split_wins", p, e, make_cfg(200, 2, 0), r, 1'b0);
        add_test(3, "start_ignore", p, e, make_cfg(200, 2, 0), r, 1'b1);

        // Chroma residual of 5 at U pixel 0 and V pixel 3
        p = flat_pixels(8'd100);
        p.u[0] = 8'd105;
        p.v[3] = 8'd95;
        add_test(4, "quant_q2", p, flat_edges(8'd100), make_cfg(10, 10, 2),
                 build_result(1'b1, I16_DC, I4_DC, I4_DC, I4_DC, I4_DC, 16'h0, 8'h81, 1'b0),
                 1'b0);
        add_test(5, "quant_q3", p, flat_edges(8'd100), make_cfg(10, 10, 3),
                 build_result(1'b1, I16_DC, I4_DC, I4_DC, I4_DC, I4_DC, 16'h0, 8'h00, 1'b1),
                 1'b0);
    endtask

    function automatic test_entry_t random_entry();
        test_entry_t t;
        t = '0;
        t.name = "random";
        for (int i = 0; i < LUMA_PIX; i++) begin
            t.pix.y[i] = 8'($urandom());
        end
        for (int i = 0; i < CHROMA_PIX; i++) begin
            t.pix.u[i] = 8'($urandom());
            t.pix.v[i] = 8'($urandom());
        end
        for (int k = 0; k < 4; k++) begin
            t.edges.top_y[k]  = 8'($urandom());
            t.edges.left_y[k] = 8'($urandom());
        end
        for (int k = 0; k < 2; k++) begin
            t.edges.top_u[k]  = 8'($urandom());
            t.edges.left_u[k] = 8'($urandom());
            t.edges.top_v[k]  = 8'($urandom());
            t.edges.left_v[k] = 8'($urandom());
        end
        t.edges.top_left_y = 8'($urandom());
        t.cfg = make_cfg($urandom() % 64, $urandom() % 16, $urandom() % 8);
        return t;
    endfunction

    task automatic run_test(input test_entry_t t, input logic from_model);
        int   cycles;
        logic seen;

        @(negedge clk);
        pix       = t.pix;
        edges     = t.edges;
        cfg       = t.cfg;
        exp_res   = t.exp;
        use_model = from_model;
        cur_name  = t.name;
        start     = 1'b1;
        n_started++;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_WAIT) begin
            @(negedge clk);
            cycles++;
            // Second start lands while the scorers run
            start = t.poke && (cycles == POKE_AT);
            seen  = done;
        end
        if (!seen) begin
            $display("%s: no done within %0d cycles of start", t.name, DONE_WAIT);
            other_errs++;
        end else if (cycles != LATENCY) begin
            $display("%s: done came %0d cycles after start, expected %0d",
                     t.name, cycles, LATENCY);
            other_errs++;
        end
        if (t.poke) begin
            repeat (QUIET) begin
                @(negedge clk);
                if (done) begin
                    $display("%s: extra done after a start that should be ignored", t.name);
                    other_errs++;
                end
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        pix       = '0;
        edges     = '0;
        cfg       = '0;
        exp_res   = '0;
        use_model = 1'b0;
        cur_name  = '0;
        void'($urandom(32'h9d21_2fb9));
        fill_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < N_DIRECTED; i++) begin
            run_test(tests[i], 1'b0);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            run_test(random_entry(), 1'b1);
        end

        repeat (4) @(negedge clk);
        if (n_done != n_started) begin
            $display("Saw %0d done pulses for %0d starts", n_done, n_started);
            other_errs++;
        end
        $display("Tests passed %0d, failed %0d, other errors %0d", n_pass, n_fail, other_errs);
        if (n_fail == 0 && other_errs == 0 && n_pass == n_started) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vp8_mode_decide.f
hdl/mode_decide_pkg.sv
hdl/intra16_scorer.sv
hdl/intra4_scorer.sv
hdl/chroma_nz.sv
hdl/mb_decide_ctrl.sv
hdl/mode_decide_top.sv
verif/mode_decide_checker.sv
verif/tb_mode_decide.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the mode decision testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vp8_mode_decide.f --top-module tb_mode_decide -o sim_mode_decide
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_mode_decide)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
